// ==== source/ecc_pkg.sv ====
// ecc_pkg: shared widths, field element types, control word and bus map of the GF(2^233) core.
package ecc_pkg;

  // field degree and the middle term of x^233 + x^74 + 1.
  localparam int field_w = 233;
  localparam int red_tap = 74;

  // register file geometry.
  localparam int rf_depth = 16;
  localparam int rf_addr_w = 4;

  // quad block exponent count width.
  localparam int quad_cnt_w = 4;

  // serial multiplier runs one cycle per bit of a1.
  localparam int mul_cycles = 233;
  localparam int mul_cnt_w = $clog2(mul_cycles);

  // wishbone word and address widths.
  localparam int wb_dat_w = 32;
  localparam int wb_adr_w = 4;

  // data window, eight words cover one element; the top word carries 9 bits.
  localparam int win_words = 8;
  localparam int win_sel_w = $clog2(win_words);
  localparam int win_tail_w = field_w - (win_words - 1) * wb_dat_w;
  localparam logic [wb_adr_w-1:0] adr_ctrl = 4'd8;

  // control word occupies the low bits of a bus word.
  localparam int ctrl_w = 25;

  typedef logic [field_w-1:0] gf_elem_t;
  typedef logic [rf_addr_w-1:0] rf_addr_t;
  typedef logic [quad_cnt_w-1:0] quad_cnt_t;
  typedef logic [mul_cnt_w-1:0] mul_cnt_t;

  // multiplicative identity in polynomial basis.
  localparam gf_elem_t gf_one = gf_elem_t'(1);

  // control word, msb first.
  typedef struct packed {
    logic mul;
    logic load;
    logic init;
    logic qin_sel;
    logic quad_en;
    quad_cnt_t quad_cnt;
    logic rb2_din_sel;
    logic rb1_din_sel;
    logic a1_sel;
    logic a2_sel;
    logic a0_sel;
    logic rb3_we;
    logic rb3_ad2;
    logic rb3_ad1;
    logic rb2_we;
    logic [1:0] rb2_ad2;
    logic [1:0] rb2_ad1;
    logic rb1_we;
    logic rb1_ad2;
    logic rb1_ad1;
  } ctrl_word_t;

  // operands from the register bank into the arithmetic unit.
  typedef struct packed {
    gf_elem_t a0;
    gf_elem_t a1;
    gf_elem_t a2;
    gf_elem_t a3;
  } gf_operands_t;

  // c0 is the product, c1 the sum.
  typedef struct packed {
    gf_elem_t c0;
    gf_elem_t c1;
  } gf_results_t;

  typedef enum logic [1:0] {
    idle,
    mul_wait,
    write,
    ack
  } ctrl_state_t;

endpackage

// ==== source/gf_ram16x233.sv ====
// gf_ram16x233: sixteen-entry field element register file, one write port and two read ports.
`timescale 1ns/1ns

module gf_ram16x233 (
  input  logic              clk,
  input  logic              we,
  input  ecc_pkg::rf_addr_t ad1,
  input  ecc_pkg::rf_addr_t ad2,
  input  ecc_pkg::gf_elem_t din,
  output ecc_pkg::gf_elem_t dout1,
  output ecc_pkg::gf_elem_t dout2
);
  import ecc_pkg::*;

  // storage in flops, no reset on the contents.
  gf_elem_t mem [rf_depth];

  // write goes to the first address port.
  always_ff @(posedge clk) begin
    if (we) begin
      mem[ad1] <= din;
    end
  end

  // both reads are combinational, so operands track the control word.
  assign dout1 = mem[ad1];
  assign dout2 = mem[ad2];

  // the write strobe comes from the controller through the register bank.
  // an unknown there would corrupt a whole element.
  a_we_known: assert property (@(posedge clk) !$isunknown(we))
    else $error("register file write enable is unknown");

endmodule

// ==== source/gf_quad_block.sv ====
// gf_quad_block: raises a field element to the power 4^n, n from 0 to 15, combinationally.
`timescale 1ns/1ns

module gf_quad_block (
  input  ecc_pkg::gf_elem_t  qin,
  input  ecc_pkg::quad_cnt_t cnt,
  output ecc_pkg::gf_elem_t  qout
);
  import ecc_pkg::*;

  gf_elem_t q;

  // squaring spreads the bits to even positions, then folds the top half.
  function automatic gf_elem_t gf_sq(input gf_elem_t a);
    logic [2*field_w-2:0] p;
    p = '0;
    for (int i = 0; i < field_w; i++) begin
      p[2*i] = a[i];
    end
    // x^233 = x^74 + 1, folded from the top down.
    // a fold may land above bit 232 again, the descending loop picks it up.
    for (int k = 2*field_w-2; k >= field_w; k--) begin
      if (p[k]) begin
        p[k - field_w + red_tap] = ~p[k - field_w + red_tap];
        p[k - field_w] = ~p[k - field_w];
      end
    end
    return p[field_w-1:0];
  endfunction

  // chain of quad steps, each two squarings.
  // steps beyond cnt pass the value through.
  always_comb begin
    q = qin;
    for (int i = 0; i < 2**quad_cnt_w; i++) begin
      if (i < int'(cnt)) begin
        q = gf_sq(gf_sq(q));
      end
    end
  end

  // cnt of zero gives qin unchanged.
  assign qout = q;

endmodule

// ==== source/gf_alu.sv ====
// Arithmetic unit gf_alu holds an msb-first bit-serial field multiplier and the field adder.
`timescale 1ns/1ns

module gf_alu (
  input  logic                  clk,
  input  logic                  rst,
  input  ecc_pkg::gf_operands_t ops,
  input  logic                  mul_start,
  output logic                  mul_done,
  output ecc_pkg::gf_results_t  res
);
  import ecc_pkg::*;

  gf_elem_t mcand;
  gf_elem_t mplier;
  gf_elem_t acc;
  gf_elem_t acc_dbl;
  mul_cnt_t bit_cnt;
  logic     busy;

  // accumulator times x, reduced by x^74 + 1 when the top bit falls out.
  always_comb begin
    acc_dbl = {acc[field_w-2:0], 1'b0};
    if (acc[field_w-1]) begin
      acc_dbl[red_tap] = ~acc_dbl[red_tap];
      acc_dbl[0] = 1'b1;
    end
  end

  // one sequencing step per cycle while busy.
  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      mul_done <= 1'b0;
      bit_cnt <= '0;
    end else begin
      mul_done <= 1'b0;
      if (mul_start) begin
        busy <= 1'b1;
        bit_cnt <= '0;
      end else if (busy) begin
        bit_cnt <= bit_cnt + 1'b1;
        // last bit of a1 consumed this cycle.
        if (bit_cnt == mul_cnt_t'(mul_cycles - 1)) begin
          busy <= 1'b0;
          mul_done <= 1'b1;
        end
      end
    end
  end

  // a0 and a1 are captured at start and a1 shifts out msb first.
  always_ff @(posedge clk) begin
    if (mul_start) begin
      mcand <= ops.a0;
      mplier <= ops.a1;
      acc <= '0;
    end else if (busy) begin
      acc <= acc_dbl ^ (mplier[field_w-1] ? mcand : '0);
      mplier <= {mplier[field_w-2:0], 1'b0};
    end
  end

  // product holds until the next start.
  assign res.c0 = acc;
  // addition in GF(2^m) is plain xor.
  assign res.c1 = ops.a2 ^ ops.a3;

  a_no_restart: assert property (@(posedge clk) disable iff (rst) mul_start |-> !busy)
    else $error("multiply started while busy");

  // one latch cycle plus mul_cycles steps separate a start from its done pulse.
  // with no restart while busy this also keeps the pulse one cycle wide.
  a_done_latency: assert property (@(posedge clk) disable iff (rst)
    mul_done |-> $past(mul_start, mul_cycles + 1))
    else $error("mul_done not mul_cycles + 1 cycles after mul_start");

endmodule

// ==== source/ecc_regbank.sv ====
// ecc_regbank: three field register files with operand routing, write-back select and quad block.
`timescale 1ns/1ns

module ecc_regbank (
  input  logic                  clk,
  input  ecc_pkg::ctrl_word_t   ctrl,
  input  logic                  wr_en,
  input  ecc_pkg::gf_elem_t     load_data,
  input  ecc_pkg::gf_results_t  res,
  output ecc_pkg::gf_operands_t ops
);
  import ecc_pkg::*;

  rf_addr_t rb1_ad1, rb1_ad2;
  rf_addr_t rb2_ad1, rb2_ad2;
  rf_addr_t rb3_ad1, rb3_ad2;
  logic     rb1_we, rb2_we, rb3_we;
  gf_elem_t rb1_din, rb2_din, rb3_din;
  gf_elem_t rb1_dout1, rb1_dout2;
  gf_elem_t rb2_dout1, rb2_dout2;
  gf_elem_t rb3_dout1, rb3_dout2;
  gf_elem_t qin, qout;

  // the control word only reaches the low entries of each file.
  assign rb1_ad1 = {3'b000, ctrl.rb1_ad1};
  assign rb1_ad2 = {3'b000, ctrl.rb1_ad2};
  assign rb2_ad1 = {2'b00, ctrl.rb2_ad1};
  assign rb2_ad2 = {2'b00, ctrl.rb2_ad2};
  assign rb3_ad1 = {3'b000, ctrl.rb3_ad1};
  assign rb3_ad2 = {3'b000, ctrl.rb3_ad2};

  // writes land only in the single strobe cycle of an instruction.
  assign rb1_we = wr_en & ctrl.rb1_we;
  assign rb2_we = wr_en & ctrl.rb2_we;
  assign rb3_we = wr_en & ctrl.rb3_we;

  gf_ram16x233 u_rb1 (
    .clk   (clk),
    .we    (rb1_we),
    .ad1   (rb1_ad1),
    .ad2   (rb1_ad2),
    .din   (rb1_din),
    .dout1 (rb1_dout1),
    .dout2 (rb1_dout2)
  );

  gf_ram16x233 u_rb2 (
    .clk   (clk),
    .we    (rb2_we),
    .ad1   (rb2_ad1),
    .ad2   (rb2_ad2),
    .din   (rb2_din),
    .dout1 (rb2_dout1),
    .dout2 (rb2_dout2)
  );

  gf_ram16x233 u_rb3 (
    .clk   (clk),
    .we    (rb3_we),
    .ad1   (rb3_ad1),
    .ad2   (rb3_ad2),
    .din   (rb3_din),
    .dout1 (rb3_dout1),
    .dout2 (rb3_dout2)
  );

  // operand routing into the arithmetic unit.
  assign ops.a0 = ctrl.a0_sel ? rb2_dout2 : rb1_dout1;
  assign ops.a2 = ctrl.a2_sel ? rb1_dout2 : rb2_dout1;
  assign ops.a1 = ctrl.a1_sel ? rb2_dout2 : rb3_dout1;
  assign ops.a3 = rb3_dout2;

  // quad input is taken from either multiplier side.
  assign qin = ctrl.qin_sel ? ops.a1 : ops.a2;

  gf_quad_block u_quad (
    .qin  (qin),
    .cnt  (ctrl.quad_cnt),
    .qout (qout)
  );

  // write-back data, init first, then load or quad, then the result select.
  assign rb1_din = ctrl.init ? res.c0 :
                   ctrl.load ? load_data :
                   ctrl.rb1_din_sel ? res.c1 : res.c0;

  assign rb2_din = ctrl.init ? res.c1 :
                   ctrl.rb2_din_sel ? res.c1 : res.c0;

  assign rb3_din = ctrl.init ? gf_one :
                   ctrl.quad_en ? qout : res.c0;

endmodule

// ==== source/ecc_wb_ctrl.sv ====
// ecc_wb_ctrl: wishbone classic slave with staging register, result window and instruction FSM.
`timescale 1ns/1ns

module ecc_wb_ctrl (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wb_cyc,
  input  logic                          wb_stb,
  input  logic                          wb_we,
  input  logic [ecc_pkg::wb_adr_w-1:0]  wb_adr,
  input  logic [ecc_pkg::wb_dat_w-1:0]  wb_dat_i,
  output logic [ecc_pkg::wb_dat_w-1:0]  wb_dat_o,
  output logic                          wb_ack,
  input  ecc_pkg::gf_elem_t             a3,
  output ecc_pkg::ctrl_word_t           ctrl,
  output ecc_pkg::gf_elem_t             load_data,
  output logic                          wr_en,
  output logic                          mul_start,
  input  logic                          mul_done
);
  import ecc_pkg::*;

  ctrl_state_t                   state;
  gf_elem_t                      staging;
  ctrl_word_t                    ctrl_new;
  logic                          req;
  logic                          win_hit;
  logic                          ctrl_hit;
  logic [win_sel_w-1:0]          win_sel;
  logic [win_words*wb_dat_w-1:0] a3_pad;
  logic [wb_dat_w-1:0]           rd_word;

  // a request is only taken in idle and never in its own ack cycle.
  assign req = wb_cyc & wb_stb & ~wb_ack & (state == idle);

  // address decode.
  assign win_hit = wb_adr < adr_ctrl;
  assign ctrl_hit = wb_adr == adr_ctrl;
  assign win_sel = wb_adr[win_sel_w-1:0];

  // a3 padded with zeros up to whole words.
  assign a3_pad = {{(win_words*wb_dat_w - field_w){1'b0}}, a3};

  assign ctrl_new = ctrl_word_t'(wb_dat_i[ctrl_w-1:0]);

  // read mux, addresses above the control word read as zero.
  always_comb begin
    if (win_hit) begin
      rd_word = a3_pad[win_sel*wb_dat_w +: wb_dat_w];
    end else if (ctrl_hit) begin
      rd_word = wb_dat_w'(ctrl);
    end else begin
      rd_word = '0;
    end
  end

  assign load_data = staging;

  // instruction sequencing.
  // control write -> optional multiply -> write strobe -> ack.
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
      ctrl <= '0;
      wb_ack <= 1'b0;
      wr_en <= 1'b0;
      mul_start <= 1'b0;
    end else begin
      wb_ack <= 1'b0;
      wr_en <= 1'b0;
      mul_start <= 1'b0;
      case (state)
        idle: begin
          if (req) begin
            if (wb_we && ctrl_hit) begin
              ctrl <= ctrl_new;
              if (ctrl_new.mul) begin
                mul_start <= 1'b1;
                state <= mul_wait;
              end else begin
                wr_en <= 1'b1;
                state <= write;
              end
            end else begin
              // window and register reads are answered right away.
              wb_ack <= 1'b1;
            end
          end
        end
        mul_wait: begin
          // product is stable from the done pulse onward.
          if (mul_done) begin
            wr_en <= 1'b1;
            state <= write;
          end
        end
        write: begin
          state <= ack;
        end
        ack: begin
          wb_ack <= 1'b1;
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // staging register and read data, no reset.
  always_ff @(posedge clk) begin
    if (req && wb_we && win_hit) begin
      // top word keeps only the bits that exist in the field.
      if (win_sel == win_sel_w'(win_words - 1)) begin
        staging[field_w-1 -: win_tail_w] <= wb_dat_i[win_tail_w-1:0];
      end else begin
        staging[win_sel*wb_dat_w +: wb_dat_w] <= wb_dat_i;
      end
    end
    if (req && !wb_we) begin
      wb_dat_o <= rd_word;
    end
  end

  // the master holds stb until it sees ack.
  a_ack_has_stb: assert property (@(posedge clk) disable iff (rst) wb_ack |-> wb_stb)
    else $error("wb_ack without wb_stb");

endmodule

// ==== source/ecc_core_top.sv ====
// ecc_core_top: GF(2^233) datapath core, bus controller with register bank and arithmetic unit.
`timescale 1ns/1ns

module ecc_core_top (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [ecc_pkg::wb_adr_w-1:0] wb_adr,
  input  logic [ecc_pkg::wb_dat_w-1:0] wb_dat_i,
  output logic [ecc_pkg::wb_dat_w-1:0] wb_dat_o,
  output logic                         wb_ack
);
  import ecc_pkg::*;

  ctrl_word_t   ctrl;
  gf_elem_t     load_data;
  logic         wr_en;
  logic         mul_start;
  logic         mul_done;
  gf_operands_t ops;
  gf_results_t  res;

  // bus slave and instruction sequencer.
  // reads back through register bank output a3.
  ecc_wb_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack    (wb_ack),
    .a3        (ops.a3),
    .ctrl      (ctrl),
    .load_data (load_data),
    .wr_en     (wr_en),
    .mul_start (mul_start),
    .mul_done  (mul_done)
  );

  ecc_regbank u_regbank (
    .clk       (clk),
    .ctrl      (ctrl),
    .wr_en     (wr_en),
    .load_data (load_data),
    .res       (res),
    .ops       (ops)
  );

  // multiplier and adder.
  gf_alu u_alu (
    .clk       (clk),
    .rst       (rst),
    .ops       (ops),
    .mul_start (mul_start),
    .mul_done  (mul_done),
    .res       (res)
  );

endmodule

// ==== tests/tb_clock_gen.sv ====
// tb_clock_gen: testbench clock and synchronous reset source for the GF(2^233) core.
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rst
);
  localparam int half_period = 20;
  localparam int rst_cycles = 5;

  // 40 ns period.
  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // reset held over the first five rising edges.
  initial begin
    rst = 1'b1;
    repeat (rst_cycles) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== tests/tb_ecc_core.sv ====
// Testbench tb_ecc_core checks the GF(2^233) core over Wishbone against reference field math.
`timescale 1ns/1ns

module tb_ecc_core;
  import ecc_pkg::*;

  localparam int ack_timeout = mul_cycles + 64;
  localparam int reset_timeout = 20;
  localparam int tail_w = field_w - (win_words - 1) * 32;
  localparam logic [31:0] lfsr_seed = 32'd31799;

  logic                clk;
  logic                rst;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [wb_adr_w-1:0] wb_adr;
  logic [31:0]         wb_dat_i;
  logic [31:0]         wb_dat_o;
  logic                wb_ack;
  logic [31:0]         lfsr_state;
  logic                gaps_on;

  tb_clock_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  ecc_core_top dut (
    .clk      (clk),
    .rst      (rst),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack   (wb_ack)
  );

  // right-shifting galois lfsr for x^32 + x^31 + x^29 + x + 1.
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hD000_0001;
    end
    return s >> 1;
  endfunction

  // bits fill from bit 0 up with one lfsr step each.
  function automatic gf_elem_t rand_bits(input int n);
    gf_elem_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v[i] = lfsr_state[0];
    end
    return v;
  endfunction

  // long division by x^233 + x^74 + 1 from the top bit down.
  function automatic gf_elem_t gf_reduce_ref(input logic [2*field_w-2:0] p);
    logic [2*field_w-2:0] r;
    logic [2*field_w-2:0] poly;
    r = p;
    poly = '0;
    poly[field_w] = 1'b1;
    poly[red_tap] = 1'b1;
    poly[0] = 1'b1;
    for (int k = 2*field_w-2; k >= field_w; k--) begin
      if (r[k]) begin
        r = r ^ (poly << (k - field_w));
      end
    end
    return r[field_w-1:0];
  endfunction

  // full carry-less product followed by one reduction.
  function automatic gf_elem_t gf_mul_ref(input gf_elem_t a, input gf_elem_t b);
    logic [2*field_w-2:0] p;
    logic [2*field_w-2:0] aw;
    p = '0;
    aw = {{(field_w-1){1'b0}}, a};
    for (int i = 0; i < field_w; i++) begin
      if (b[i]) begin
        p = p ^ (aw << i);
      end
    end
    return gf_reduce_ref(p);
  endfunction

  function automatic gf_elem_t gf_sq_ref(input gf_elem_t a);
    return gf_mul_ref(a, a);
  endfunction

  // a^(4^n) as n rounds of two squarings.
  function automatic gf_elem_t gf_quad_ref(input gf_elem_t a, input quad_cnt_t n);
    gf_elem_t r;
    r = a;
    for (int i = 0; i < int'(n); i++) begin
      r = gf_sq_ref(gf_sq_ref(r));
    end
    return r;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input gf_elem_t got, input gf_elem_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic wait_reset_release();
    int waited;
    waited = 0;
    @(negedge clk);
    while (rst !== 1'b0) begin
      waited++;
      if (waited > reset_timeout) begin
        fail_run("reset was never released");
      end
      @(negedge clk);
    end
  endtask

  // up to seven idle cycles before a request when gaps are on.
  task automatic idle_gap();
    gf_elem_t r;
    if (gaps_on) begin
      r = rand_bits(3);
      repeat (int'(r[2:0])) @(posedge clk);
    end
  endtask

  // ack is sampled on the falling edge and the request drops on the next rising edge.
  task automatic wb_access(input logic we, input logic [wb_adr_w-1:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    idle_gap();
    @(posedge clk);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we <= we;
    wb_adr <= adr;
    wb_dat_i <= wdata;
    waited = 0;
    @(negedge clk);
    while (!wb_ack) begin
      waited++;
      if (waited > ack_timeout) begin
        fail_run($sformatf("no wb_ack within %0d cycles for address %0d", ack_timeout, adr));
      end
      @(negedge clk);
    end
    rdata = wb_dat_o;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
  endtask

  task automatic wb_write(input logic [wb_adr_w-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic wb_read(input logic [wb_adr_w-1:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, 32'h0, data);
  endtask

  // the top word carries junk above bit 8 that the core must drop.
  task automatic load_staging(input gf_elem_t x);
    for (int i = 0; i < win_words - 1; i++) begin
      wb_write(wb_adr_w'(i), x[i*32 +: 32]);
    end
    wb_write(wb_adr_w'(win_words - 1), {{(32-tail_w){1'b1}}, x[field_w-1 -: tail_w]});
  endtask

  task automatic read_window(output gf_elem_t v);
    logic [31:0] w;
    v = '0;
    for (int i = 0; i < win_words; i++) begin
      wb_read(wb_adr_w'(i), w);
      if (i == win_words - 1) begin
        check_value("wb_dat_o word 7 pad", field_w'(w[31:tail_w]), '0);
        v[field_w-1 -: tail_w] = w[tail_w-1:0];
      end else begin
        v[i*32 +: 32] = w;
      end
    end
  endtask

  task automatic run_instr(input ctrl_word_t c);
    wb_write(adr_ctrl, 32'(c));
  endtask

  // a select-only word points a3 at rb3[idx] before the window is read.
  task automatic read_rb3(input logic idx, output gf_elem_t v);
    ctrl_word_t c;
    c = '0;
    c.rb3_ad2 = idx;
    run_instr(c);
    read_window(v);
  endtask

  task automatic load_rb1(input logic idx, input gf_elem_t x);
    ctrl_word_t c;
    load_staging(x);
    c = '0;
    c.load = 1'b1;
    c.rb1_we = 1'b1;
    c.rb1_ad1 = idx;
    run_instr(c);
  endtask

  task automatic init_rb3(input logic idx);
    ctrl_word_t c;
    c = '0;
    c.init = 1'b1;
    c.rb3_we = 1'b1;
    c.rb3_ad1 = idx;
    run_instr(c);
  endtask

  // rb3[dst] takes rb1[src]^(4^cnt) through a2.
  // cnt zero makes it a plain copy.
  task automatic quad_rb1_to_rb3(input logic src, input logic dst, input quad_cnt_t cnt);
    ctrl_word_t c;
    c = '0;
    c.quad_en = 1'b1;
    c.quad_cnt = cnt;
    c.a2_sel = 1'b1;
    c.rb1_ad2 = src;
    c.rb3_we = 1'b1;
    c.rb3_ad1 = dst;
    run_instr(c);
  endtask

  // rb2[dst] takes c1 = rb1[src] xor rb3[sel].
  task automatic sum_into_rb2(input logic src, input logic sel, input logic [1:0] dst);
    ctrl_word_t c;
    c = '0;
    c.a2_sel = 1'b1;
    c.rb1_ad2 = src;
    c.rb3_ad2 = sel;
    c.rb2_din_sel = 1'b1;
    c.rb2_we = 1'b1;
    c.rb2_ad1 = dst;
    run_instr(c);
  endtask

  // needs rb3[0] holding zero for the move into rb2.
  task automatic check_random_mul();
    ctrl_word_t c;
    gf_elem_t x, y, v;
    x = rand_bits(field_w);
    y = rand_bits(field_w);
    load_rb1(1'b0, x);
    load_rb1(1'b1, y);
    sum_into_rb2(1'b1, 1'b0, 2'd0);
    c = '0;
    c.mul = 1'b1;
    c.a1_sel = 1'b1;
    c.rb2_ad2 = 2'd0;
    c.rb3_we = 1'b1;
    c.rb3_ad1 = 1'b1;
    run_instr(c);
    read_rb3(1'b1, v);
    check_value("rb3[1] x*y", v, gf_mul_ref(x, y));
  endtask

  // a xor b lands in rb2[1] and comes back through a multiply by one.
  task automatic check_add();
    ctrl_word_t c;
    gf_elem_t a, b, v;
    a = rand_bits(field_w);
    b = rand_bits(field_w);
    load_rb1(1'b1, a);
    quad_rb1_to_rb3(1'b1, 1'b1, 4'd0);
    load_rb1(1'b1, b);
    sum_into_rb2(1'b1, 1'b1, 2'd1);
    init_rb3(1'b1);
    c = '0;
    c.mul = 1'b1;
    c.a0_sel = 1'b1;
    c.rb2_ad2 = 2'd1;
    c.rb3_we = 1'b1;
    c.rb3_ad1 = 1'b1;
    run_instr(c);
    read_rb3(1'b1, v);
    check_value("rb3[1] a+b", v, a ^ b);
  endtask

  initial begin
    ctrl_word_t c;
    gf_elem_t x, v;
    quad_cnt_t cnt;
    logic [31:0] w;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we <= 1'b0;
    wb_adr <= '0;
    wb_dat_i <= '0;
    lfsr_state = lfsr_seed;
    gaps_on = 1'b0;
    wait_reset_release();

    // idle bus and a cleared control word after reset.
    repeat (8) begin
      @(negedge clk);
      check_value("wb_ack", field_w'(wb_ack), '0);
    end
    wb_read(adr_ctrl, w);
    check_value("ctrl after reset", field_w'(w), '0);

    // init puts one into rb3[0].
    // init is bit 22 and rb3_we bit 10.
    init_rb3(1'b0);
    wb_read(adr_ctrl, w);
    check_value("ctrl readback", field_w'(w), field_w'(32'h0040_0400));
    read_rb3(1'b0, v);
    check_value("rb3[0] one", v, field_w'(1));

    // x times one into rb3[1].
    x = rand_bits(field_w);
    load_rb1(1'b0, x);
    init_rb3(1'b1);
    c = '0;
    c.mul = 1'b1;
    c.rb3_we = 1'b1;
    c.rb3_ad1 = 1'b1;
    run_instr(c);
    read_rb3(1'b1, v);
    check_value("rb3[1] x*1", v, x);

    // rb3[0] cleared so that a3 adds nothing when moving into rb2.
    load_rb1(1'b1, '0);
    quad_rb1_to_rb3(1'b1, 1'b0, 4'd0);
    repeat (4) check_random_mul();

    // quad from a2 (rb1 port 2) and from a1 (rb2 port 2).
    repeat (3) begin
      x = rand_bits(field_w);
      cnt = quad_cnt_t'(rand_bits(4));
      load_rb1(1'b1, x);
      quad_rb1_to_rb3(1'b1, 1'b1, cnt);
      read_rb3(1'b1, v);
      check_value("rb3[1] quad a2", v, gf_quad_ref(x, cnt));
      sum_into_rb2(1'b1, 1'b0, 2'd2);
      cnt = quad_cnt_t'(rand_bits(4));
      c = '0;
      c.quad_en = 1'b1;
      c.quad_cnt = cnt;
      c.qin_sel = 1'b1;
      c.a1_sel = 1'b1;
      c.rb2_ad2 = 2'd2;
      c.rb3_we = 1'b1;
      c.rb3_ad1 = 1'b1;
      run_instr(c);
      read_rb3(1'b1, v);
      check_value("rb3[1] quad a1", v, gf_quad_ref(x, cnt));
    end

    // add path and multiplies with random idle gaps between requests.
    gaps_on = 1'b1;
    repeat (3) begin
      check_add();
      check_random_mul();
    end

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== compile.f ====
source/ecc_pkg.sv
source/gf_ram16x233.sv
source/gf_quad_block.sv
source/gf_alu.sv
source/ecc_regbank.sv
source/ecc_wb_ctrl.sv
source/ecc_core_top.sv
tests/tb_clock_gen.sv
tests/tb_ecc_core.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_ecc_core -f compile.f > sim.log 2>&1 &&
  ./obj_dir/Vtb_ecc_core >> sim.log 2>&1 ||
  echo "Verification failed" >> sim.log
cat sim.log
if grep -q "Verification failed" sim.log; then
  exit 1
fi
exit 0
